/* src/udma_rx_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths and encodings of the rx write path
// the bus is fixed at 32 bits with 4 byte lanes
// the fixed prefixes assume an in-memory width of 20 bits or less
////////////////////////////////////////////////////////////

package udma_rx_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH = 32;
    localparam int TRANS_SIZE = 16;   // byte counter per channel

    // transfer size of one sample
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } datasize_e;

    // selects the upper address bits
    typedef enum logic [1:0] {
        DEST_L2      = 2'b00,
        DEST_PERIPH  = 2'b01,
        DEST_CLUSTER = 2'b10,
        DEST_CUSTOM  = 2'b11
    } dest_e;

    typedef enum logic {
        WR_FIRST  = 1'b0,
        WR_SECOND = 1'b1    // remaining bytes of a split record
    } wr_state_e;

    localparam logic [7:0]  PREFIX_L2      = 8'h1C;    // bits 31:24
    localparam logic [11:0] PREFIX_PERIPH  = 12'h1A1;  // bits 31:20
    localparam logic [7:0]  PREFIX_CLUSTER = 8'h10;    // bits 31:24

endpackage

/* src/rx_arbiter.sv */
////////////////////////////////////////////////////////////
// round-robin arbiter, grant is combinational from req_i
// the priority pointer only moves on ack_i
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rx_arbiter #(
    parameter int N_CHANNELS = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [N_CHANNELS-1:0] req_i,
    input  logic                  ack_i,
    output logic [N_CHANNELS-1:0] grant_o,
    output logic                  any_grant_o
);

    localparam int PTR_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [PTR_W-1:0] r_ptr;
    logic [PTR_W-1:0] s_grant_idx;
    logic [PTR_W-1:0] s_next_ptr;

    // first requester at or after the pointer
    always_comb
    begin
        int idx;
        grant_o     = '0;
        any_grant_o = 1'b0;
        s_grant_idx = '0;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            idx = int'(r_ptr) + i;
            if (idx >= N_CHANNELS)
                idx = idx - N_CHANNELS;
            if (req_i[idx] && !any_grant_o)
            begin
                grant_o[idx] = 1'b1;
                any_grant_o  = 1'b1;
                s_grant_idx  = PTR_W'(idx);
            end
        end
    end

    assign s_next_ptr = (int'(s_grant_idx) == N_CHANNELS - 1) ? '0 : s_grant_idx + 1'b1;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_ptr <= '0;
        else if (ack_i && any_grant_o)
            r_ptr <= s_next_ptr;   // granted channel drops to lowest priority
    end

endmodule

/* src/rx_chan_addrgen.sv */
////////////////////////////////////////////////////////////
// linear address generator for one receive channel
// a clear wins over a start in the same cycle
// the count is in bytes, a sample of size 0 is not possible
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rx_chan_addrgen #(
    parameter int L2_AWIDTH = 16
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               cfg_start_i,
    input  logic                               cfg_clr_i,
    input  logic [L2_AWIDTH-1:0]               cfg_addr_i,
    input  logic [udma_rx_pkg::TRANS_SIZE-1:0] cfg_size_i,
    input  logic                               sample_i,
    input  udma_rx_pkg::datasize_e            size_i,
    output logic [L2_AWIDTH-1:0]               addr_o,
    output logic                               en_o,
    output logic                               evt_o
);

    import udma_rx_pkg::*;

    logic [L2_AWIDTH-1:0]  r_addr;
    logic [TRANS_SIZE-1:0] r_bytes;
    logic                  r_en;
    logic                  r_evt;
    logic [2:0]            s_incr;
    logic                  s_last;

    always_comb
    begin
        case (size_i)
            SIZE_HALF: s_incr = 3'd2;
            SIZE_WORD: s_incr = 3'd4;
            default:   s_incr = 3'd1;
        endcase
    end

    // this sample uses up the remaining count
    assign s_last = (r_bytes <= TRANS_SIZE'(s_incr));

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_addr  <= '0;
            r_bytes <= '0;
            r_en    <= 1'b0;
            r_evt   <= 1'b0;
        end
        else
        begin
            r_evt <= 1'b0;
            if (cfg_clr_i)
                r_en <= 1'b0;
            else if (cfg_start_i)
            begin
                r_addr  <= cfg_addr_i;
                r_bytes <= cfg_size_i;
                r_en    <= 1'b1;
            end
            else if (sample_i && r_en)
            begin
                r_addr  <= r_addr + L2_AWIDTH'(s_incr);
                r_bytes <= r_bytes - TRANS_SIZE'(s_incr);
                if (s_last)
                begin
                    r_en  <= 1'b0;
                    r_evt <= 1'b1;   // end of transfer, one cycle after the sample
                end
            end
        end
    end

    assign addr_o = r_addr;
    assign en_o   = r_en & ~cfg_clr_i;   // clear stops requests in the same cycle
    assign evt_o  = r_evt;

endmodule

/* src/rx_ingress.sv */
////////////////////////////////////////////////////////////
// sample stage between the channels and the record FIFO
// grant_i must be one-hot or zero
// holds one record while the FIFO is full
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rx_ingress #(
    parameter int N_CHANNELS = 4,
    parameter int L2_AWIDTH  = 16
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,
    input  logic [N_CHANNELS-1:0]                              grant_i,
    input  logic                                               any_grant_i,
    input  logic [N_CHANNELS-1:0][udma_rx_pkg::DATA_WIDTH-1:0] ch_data_i,
    input  udma_rx_pkg::datasize_e [N_CHANNELS-1:0]           ch_size_i,
    input  udma_rx_pkg::dest_e [N_CHANNELS-1:0]               ch_dest_i,
    input  logic [N_CHANNELS-1:0][L2_AWIDTH-1:0]               ch_addr_i,
    input  logic                                               fifo_full_i,
    output logic                                               sample_o,
    output logic [N_CHANNELS-1:0]                              ch_ready_o,
    output logic                                               push_o,
    output logic [udma_rx_pkg::DATA_WIDTH-1:0]                 rec_data_o,
    output logic [L2_AWIDTH-1:0]                               rec_addr_o,
    output udma_rx_pkg::datasize_e                            rec_size_o,
    output udma_rx_pkg::dest_e                                rec_dest_o
);

    import udma_rx_pkg::*;

    logic [DATA_WIDTH-1:0] s_data;
    logic [L2_AWIDTH-1:0]  s_addr;
    datasize_e             s_size;
    dest_e                 s_dest;
    logic                  r_valid;

    // select the granted channel
    always_comb
    begin
        s_data = '0;
        s_addr = '0;
        s_size = SIZE_BYTE;
        s_dest = DEST_L2;
        for (int c = 0; c < N_CHANNELS; c++)
        begin
            if (grant_i[c])
            begin
                s_data = ch_data_i[c];
                s_addr = ch_addr_i[c];
                s_size = ch_size_i[c];
                s_dest = ch_dest_i[c];
            end
        end
    end

    // the held record leaves in the cycle the next one is taken
    assign push_o     = r_valid & ~fifo_full_i;
    assign sample_o   = any_grant_i & (~r_valid | ~fifo_full_i);
    assign ch_ready_o = grant_i & {N_CHANNELS{sample_o}};

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_valid <= 1'b0;
        else if (sample_o)
            r_valid <= 1'b1;
        else if (push_o)
            r_valid <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (sample_o)
        begin
            rec_data_o <= s_data;
            rec_addr_o <= s_addr;   // address before this sample advances it
            rec_size_o <= s_size;
            rec_dest_o <= s_dest;
        end
    end

endmodule

/* src/rx_fifo.sv */
////////////////////////////////////////////////////////////
// first-word-fall-through FIFO, head is valid while not empty
// a push while full and a pop while empty are ignored
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rx_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    output logic             full_o,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0] r_wptr;
    logic [PTR_W-1:0] r_rptr;
    logic [CNT_W-1:0] r_count;
    logic             s_push;
    logic             s_pop;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
        if (int'(ptr) == DEPTH - 1)
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full_o  = (r_count == CNT_W'(DEPTH));
    assign valid_o = (r_count != '0);
    assign data_o  = r_mem[r_rptr];
    assign s_push  = push_i & ~full_o;
    assign s_pop   = pop_i & valid_o;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wptr  <= '0;
            r_rptr  <= '0;
            r_count <= '0;
        end
        else
        begin
            if (s_push)
                r_wptr <= wrap_inc(r_wptr);
            if (s_pop)
                r_rptr <= wrap_inc(r_rptr);
            if (s_push && !s_pop)
                r_count <= r_count + 1'b1;
            else if (s_pop && !s_push)
                r_count <= r_count - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (s_push)
            r_mem[r_wptr] <= data_i;
    end

endmodule

/* src/rx_l2_writer.sv */
////////////////////////////////////////////////////////////
// drains FIFO records onto the 32-bit L2 request/grant bus
// a record crossing a word boundary takes two beats
// unused byte lanes carry zero data
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rx_l2_writer #(
    parameter int L2_AWIDTH = 16
) (
    input  logic                                         clk_i,
    input  logic                                         rstn_i,
    input  logic                                         valid_i,
    input  logic [udma_rx_pkg::DATA_WIDTH-1:0]           data_i,
    input  logic [L2_AWIDTH-1:0]                         addr_i,
    input  udma_rx_pkg::datasize_e                      size_i,
    input  udma_rx_pkg::dest_e                          dest_i,
    input  logic [udma_rx_pkg::ADDR_WIDTH-L2_AWIDTH-1:0] prefix_i,
    output logic                                         pop_o,
    output logic                                         l2_req_o,
    input  logic                                         l2_gnt_i,
    output logic [udma_rx_pkg::ADDR_WIDTH-1:0]           l2_addr_o,
    output logic [udma_rx_pkg::BE_WIDTH-1:0]             l2_be_o,
    output logic [udma_rx_pkg::DATA_WIDTH-1:0]           l2_wdata_o
);

    import udma_rx_pkg::*;

    localparam int ALIGN_W = $clog2(BE_WIDTH);

    wr_state_e                   r_state;
    logic [BE_WIDTH-1:0]         s_mask;     // enables at lane 0
    logic [DATA_WIDTH-1:0]       s_data_m;
    logic [2*BE_WIDTH-1:0]       s_be_wide;
    logic [2*DATA_WIDTH-1:0]     s_data_wide;
    logic [ALIGN_W-1:0]          s_lane;
    logic                        s_split;
    logic                        s_second;
    logic [L2_AWIDTH-ALIGN_W-1:0] s_word;

    always_comb
    begin
        case (size_i)
            SIZE_HALF: s_mask = 4'b0011;
            SIZE_WORD: s_mask = 4'b1111;
            default:   s_mask = 4'b0001;
        endcase
        for (int b = 0; b < BE_WIDTH; b++)
            s_data_m[8*b +: 8] = s_mask[b] ? data_i[8*b +: 8] : 8'h00;
    end

    // shift into a two-word window, the upper half is the second beat
    assign s_lane      = addr_i[ALIGN_W-1:0];
    assign s_be_wide   = {{BE_WIDTH{1'b0}}, s_mask} << s_lane;
    assign s_data_wide = {{DATA_WIDTH{1'b0}}, s_data_m} << {s_lane, 3'b000};
    assign s_split     = |s_be_wide[2*BE_WIDTH-1:BE_WIDTH];
    assign s_second    = (r_state == WR_SECOND);

    assign l2_req_o   = valid_i;
    assign l2_be_o    = s_second ? s_be_wide[2*BE_WIDTH-1:BE_WIDTH] : s_be_wide[BE_WIDTH-1:0];
    assign l2_wdata_o = s_second ? s_data_wide[2*DATA_WIDTH-1:DATA_WIDTH]
                                 : s_data_wide[DATA_WIDTH-1:0];
    assign pop_o      = valid_i & l2_gnt_i & (s_second | ~s_split);

    // second beat goes to the next word
    assign s_word = addr_i[L2_AWIDTH-1:ALIGN_W] + (L2_AWIDTH-ALIGN_W)'(s_second);

    always_comb
    begin
        l2_addr_o = {{(ADDR_WIDTH-L2_AWIDTH){1'b0}}, s_word, {ALIGN_W{1'b0}}};
        case (dest_i)
            DEST_L2:      l2_addr_o[ADDR_WIDTH-1:24] = PREFIX_L2;
            DEST_PERIPH:  l2_addr_o[ADDR_WIDTH-1:20] = PREFIX_PERIPH;
            DEST_CLUSTER: l2_addr_o[ADDR_WIDTH-1:24] = PREFIX_CLUSTER;
            default:      l2_addr_o[ADDR_WIDTH-1:L2_AWIDTH] = prefix_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // beat sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= WR_FIRST;
        else if (valid_i && l2_gnt_i)
        begin
            if (!s_second && s_split)
                r_state <= WR_SECOND;
            else
                r_state <= WR_FIRST;
        end
    end

endmodule

/* src/udma_rx_top.sv */
////////////////////////////////////////////////////////////
// receive-side DMA write path, linear channels only
// channel vectors are packed per channel, index = channel
// up to FIFO_DEPTH+1 records are in flight
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module udma_rx_top #(
    parameter int N_CHANNELS = 4,
    parameter int L2_AWIDTH  = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                               clk_i,
    input  logic                                               rstn_i,
    input  logic [N_CHANNELS-1:0]                              cfg_start_i,
    input  logic [N_CHANNELS-1:0]                              cfg_clr_i,
    input  logic [N_CHANNELS-1:0][L2_AWIDTH-1:0]               cfg_addr_i,
    input  logic [N_CHANNELS-1:0][udma_rx_pkg::TRANS_SIZE-1:0] cfg_size_i,
    input  logic [N_CHANNELS-1:0]                              ch_valid_i,
    input  logic [N_CHANNELS-1:0][udma_rx_pkg::DATA_WIDTH-1:0] ch_data_i,
    input  udma_rx_pkg::datasize_e [N_CHANNELS-1:0]           ch_size_i,
    input  udma_rx_pkg::dest_e [N_CHANNELS-1:0]               ch_dest_i,
    output logic [N_CHANNELS-1:0]                              ch_ready_o,
    output logic [N_CHANNELS-1:0]                              ch_busy_o,
    output logic [N_CHANNELS-1:0]                              evt_o,
    input  logic [udma_rx_pkg::ADDR_WIDTH-L2_AWIDTH-1:0]       l2_prefix_i,
    output logic                                               l2_req_o,
    input  logic                                               l2_gnt_i,
    output logic [udma_rx_pkg::ADDR_WIDTH-1:0]                 l2_addr_o,
    output logic [udma_rx_pkg::BE_WIDTH-1:0]                   l2_be_o,
    output logic [udma_rx_pkg::DATA_WIDTH-1:0]                 l2_wdata_o
);

    import udma_rx_pkg::*;

    localparam int SIZE_W = $bits(datasize_e);
    localparam int DEST_W = $bits(dest_e);
    localparam int REC_W  = DATA_WIDTH + L2_AWIDTH + SIZE_W + DEST_W;

    logic [N_CHANNELS-1:0]                s_req;
    logic [N_CHANNELS-1:0]                s_grant;
    logic                                 s_any_grant;
    logic                                 s_sample;
    logic [N_CHANNELS-1:0][L2_AWIDTH-1:0] s_ch_addr;
    logic                                 s_push;
    logic                                 s_fifo_full;
    logic [DATA_WIDTH-1:0]                s_rec_data;
    logic [L2_AWIDTH-1:0]                 s_rec_addr;
    datasize_e                            s_rec_size;
    dest_e                                s_rec_dest;
    logic [REC_W-1:0]                     s_fifo_in;
    logic [REC_W-1:0]                     s_fifo_out;
    logic                                 s_fifo_valid;
    logic                                 s_pop;

    assign s_req = ch_valid_i & ch_busy_o;   // only enabled channels compete

    // record layout {dest, size, addr, data}
    assign s_fifo_in = {s_rec_dest, s_rec_size, s_rec_addr, s_rec_data};

    rx_arbiter #(.N_CHANNELS(N_CHANNELS)) u_arbiter (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (s_req),
        .ack_i       (s_sample),
        .grant_o     (s_grant),
        .any_grant_o (s_any_grant)
    );

    for (genvar c = 0; c < N_CHANNELS; c++)
    begin : g_chan
        rx_chan_addrgen #(.L2_AWIDTH(L2_AWIDTH)) u_addrgen (
            .clk_i       (clk_i),
            .rstn_i      (rstn_i),
            .cfg_start_i (cfg_start_i[c]),
            .cfg_clr_i   (cfg_clr_i[c]),
            .cfg_addr_i  (cfg_addr_i[c]),
            .cfg_size_i  (cfg_size_i[c]),
            .sample_i    (ch_ready_o[c]),
            .size_i      (ch_size_i[c]),
            .addr_o      (s_ch_addr[c]),
            .en_o        (ch_busy_o[c]),
            .evt_o       (evt_o[c])
        );
    end

    rx_ingress #(.N_CHANNELS(N_CHANNELS), .L2_AWIDTH(L2_AWIDTH)) u_ingress (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .grant_i     (s_grant),
        .any_grant_i (s_any_grant),
        .ch_data_i   (ch_data_i),
        .ch_size_i   (ch_size_i),
        .ch_dest_i   (ch_dest_i),
        .ch_addr_i   (s_ch_addr),
        .fifo_full_i (s_fifo_full),
        .sample_o    (s_sample),
        .ch_ready_o  (ch_ready_o),
        .push_o      (s_push),
        .rec_data_o  (s_rec_data),
        .rec_addr_o  (s_rec_addr),
        .rec_size_o  (s_rec_size),
        .rec_dest_o  (s_rec_dest)
    );

    rx_fifo #(.WIDTH(REC_W), .DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (s_push),
        .data_i  (s_fifo_in),
        .full_o  (s_fifo_full),
        .pop_i   (s_pop),
        .data_o  (s_fifo_out),
        .valid_o (s_fifo_valid)
    );

    rx_l2_writer #(.L2_AWIDTH(L2_AWIDTH)) u_writer (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .valid_i    (s_fifo_valid),
        .data_i     (s_fifo_out[DATA_WIDTH-1:0]),
        .addr_i     (s_fifo_out[DATA_WIDTH +: L2_AWIDTH]),
        .size_i     (datasize_e'(s_fifo_out[DATA_WIDTH+L2_AWIDTH +: SIZE_W])),
        .dest_i     (dest_e'(s_fifo_out[REC_W-1 -: DEST_W])),
        .prefix_i   (l2_prefix_i),
        .pop_o      (s_pop),
        .l2_req_o   (l2_req_o),
        .l2_gnt_i   (l2_gnt_i),
        .l2_addr_o  (l2_addr_o),
        .l2_be_o    (l2_be_o),
        .l2_wdata_o (l2_wdata_o)
    );

endmodule

/* dv/udma_rx_checker.sv */
////////////////////////////////////////////////////////////
// handshake assertions, bound into every udma_rx_top
// bus rules are checked on the rising clock edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module udma_rx_checker #(
    parameter int N_CHANNELS = 4
) (
    input logic                              clk_i,
    input logic                              rstn_i,
    input logic [N_CHANNELS-1:0]             ch_ready_o,
    input logic                              l2_req_o,
    input logic                              l2_gnt_i,
    input logic [udma_rx_pkg::ADDR_WIDTH-1:0] l2_addr_o,
    input logic [udma_rx_pkg::BE_WIDTH-1:0]   l2_be_o,
    input logic [udma_rx_pkg::DATA_WIDTH-1:0] l2_wdata_o
);

    a_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o && !l2_gnt_i |=> l2_req_o)
        else $error("l2_req_o dropped before l2_gnt_i");

    // a waiting beat keeps address, enables and data
    a_beat_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o && !l2_gnt_i |=> $stable(l2_addr_o) && $stable(l2_be_o) && $stable(l2_wdata_o))
        else $error("bus beat changed while waiting for l2_gnt_i");

    a_ready_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(ch_ready_o))
        else $error("more than one ch_ready_o pulse in a cycle");

    a_no_req_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !l2_req_o)
        else $error("l2_req_o high during reset");

endmodule

bind udma_rx_top udma_rx_checker #(.N_CHANNELS(N_CHANNELS)) u_checker (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .ch_ready_o (ch_ready_o),
    .l2_req_o   (l2_req_o),
    .l2_gnt_i   (l2_gnt_i),
    .l2_addr_o  (l2_addr_o),
    .l2_be_o    (l2_be_o),
    .l2_wdata_o (l2_wdata_o)
);

/* dv/udma_rx_tb.sv */
////////////////////////////////////////////////////////////
// testbench for udma_rx_top with default parameters
// the model builds addresses for an in-memory width of 16
// inputs change on the falling edge, handshakes are read 1 ns later
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module udma_rx_tb;

    import udma_rx_pkg::*;

    localparam int N         = 4;
    localparam int AW        = 16;
    localparam int M_ALIGNED = 0;
    localparam int M_SPLIT   = 1;
    localparam int M_PREFIX  = 2;
    localparam int M_EVT     = 3;
    localparam int M_STRESS  = 4;

    logic                         clk_i;
    logic                         rstn_i;
    logic [N-1:0]                 cfg_start_i;
    logic [N-1:0]                 cfg_clr_i;
    logic [N-1:0][AW-1:0]         cfg_addr_i;
    logic [N-1:0][TRANS_SIZE-1:0] cfg_size_i;
    logic [N-1:0]                 ch_valid_i;
    logic [N-1:0][DATA_WIDTH-1:0] ch_data_i;
    datasize_e [N-1:0]            ch_size_i;
    dest_e [N-1:0]                ch_dest_i;
    logic [N-1:0]                 ch_ready_o;
    logic [N-1:0]                 ch_busy_o;
    logic [N-1:0]                 evt_o;
    logic [ADDR_WIDTH-AW-1:0]     l2_prefix_i;
    logic                         l2_req_o;
    logic                         l2_gnt_i;
    logic [ADDR_WIDTH-1:0]        l2_addr_o;
    logic [BE_WIDTH-1:0]          l2_be_o;
    logic [DATA_WIDTH-1:0]        l2_wdata_o;

    logic [67:0]   exp_q[$];     // {addr, be, data} per bus beat
    logic [AW-1:0] trk_addr [N];
    int            left [N];
    int            evt_cnt [N];
    logic [N-1:0]  seen [N];     // channels sampled while this one waits
    logic [N-1:0]  model_en;
    logic [N-1:0]  exp_evt;
    logic [N-1:0]  taken;        // words sampled at the last rising edge
    logic [3:0]    dest_seen;
    int            mode;
    int            stall_left;
    int            split_cnt;
    int            err_count;
    int            check_count;
    int            test_count;
    int            wd_count;
    int            wd_limit;
    bit            wd_armed;
    string         test_name;

    udma_rx_top u_udma_rx_top (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        err_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] full_addr(input dest_e dest, input logic [AW-1:0] base);
        case (dest)
            DEST_L2:      return {PREFIX_L2, 8'h00, base};
            DEST_PERIPH:  return {PREFIX_PERIPH, 4'h0, base};
            DEST_CLUSTER: return {PREFIX_CLUSTER, 8'h00, base};
            default:      return {l2_prefix_i, base};
        endcase
    endfunction

    // one sampled word becomes one or two beats, bytes placed one by one
    task automatic expect_beats(input int c);
        int            n;
        int            pos;
        logic [7:0]    be_w;
        logic [63:0]   d_w;
        logic [AW-1:0] base;
        n    = (ch_size_i[c] == SIZE_WORD) ? 4 : (ch_size_i[c] == SIZE_HALF) ? 2 : 1;
        base = {trk_addr[c][AW-1:2], 2'b00};
        be_w = '0;
        d_w  = '0;
        for (int i = 0; i < n; i++)
        begin
            pos              = int'(trk_addr[c][1:0]) + i;
            be_w[pos]        = 1'b1;
            d_w[8*pos +: 8]  = ch_data_i[c][8*i +: 8];
        end
        exp_q.push_back({full_addr(ch_dest_i[c], base), be_w[3:0], d_w[31:0]});
        if (be_w[7:4] != '0)
        begin
            exp_q.push_back({full_addr(ch_dest_i[c], base + AW'(4)), be_w[7:4], d_w[63:32]});
            split_cnt++;
        end
        dest_seen[ch_dest_i[c]] = 1'b1;
        trk_addr[c] = trk_addr[c] + AW'(n);
        left[c]     = left[c] - n;
        if (left[c] <= 0)
        begin
            model_en[c] = 1'b0;
            exp_evt[c]  = 1'b1;    // pulse seen at the next falling edge
        end
    endtask

    // checks the registered outputs, drives the next cycle, then watches its handshakes
    task automatic cycle_step();
        logic [N-1:0] rdy;
        logic [67:0]  beat;
        compare("evt_o", 32'(evt_o), 32'(exp_evt));
        compare("ch_busy_o", 32'(ch_busy_o), 32'(model_en));
        for (int c = 0; c < N; c++)
            evt_cnt[c] += int'(evt_o[c]);
        exp_evt = '0;

        // channel drivers, a word stays until the edge that takes it
        for (int c = 0; c < N; c++)
        begin
            if (taken[c] || !ch_valid_i[c])
            begin
                ch_valid_i[c] = model_en[c] && (mode == M_STRESS || $urandom_range(0, 99) < 70);
                ch_data_i[c]  = $urandom;
                ch_dest_i[c]  = dest_e'($urandom_range(0, 3));
                ch_size_i[c]  = datasize_e'($urandom_range(0, 2));
                if (mode == M_ALIGNED)
                    ch_size_i[c] = (c == 1) ? SIZE_HALF : (c == 2) ? SIZE_BYTE : SIZE_WORD;
            end
        end

        // bus responder
        if (mode == M_STRESS && stall_left > 0)
        begin
            l2_gnt_i   = 1'b0;
            stall_left = stall_left - 1;
        end
        else if (mode == M_STRESS)
        begin
            l2_gnt_i = 1'b1;
            if ($urandom_range(0, 99) < 30)
                stall_left = $urandom_range(5, 24);   // long grant gap
        end
        else
            l2_gnt_i = ($urandom_range(0, 99) < 60);

        // ready and grant below belong to the coming rising edge
        #1;
        rdy   = ch_ready_o;
        taken = rdy;
        if (l2_req_o && l2_gnt_i)
        begin
            if (exp_q.size() == 0)
                note_error("bus write with no expected beat");
            else
            begin
                beat = exp_q.pop_front();
                compare("l2_addr_o", l2_addr_o, beat[67:36]);
                compare("l2_be_o", 32'(l2_be_o), 32'(beat[35:32]));
                compare("l2_wdata_o", l2_wdata_o, beat[31:0]);
            end
        end
        for (int c = 0; c < N; c++)
        begin
            if (rdy[c] && !(model_en[c] && ch_valid_i[c]))
                note_error($sformatf("ready on channel %0d without an enabled valid word", c));
            else if (rdy[c])
            begin
                for (int w = 0; w < N; w++)
                begin
                    if (w != c && model_en[w] && ch_valid_i[w] && seen[w][c])
                        note_error($sformatf("channel %0d sampled twice while %0d waits", c, w));
                    seen[w][c] = 1'b1;
                end
                seen[c] = '0;
                expect_beats(c);
            end
        end
        for (int w = 0; w < N; w++)
        begin
            if (!(model_en[w] && ch_valid_i[w]))
                seen[w] = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic run_test(input string name, input int test_mode);
        int total_bytes;
        int errs_before;
        total_bytes = 0;
        errs_before = err_count;
        test_name   = name;
        mode        = test_mode;
        split_cnt   = 0;
        dest_seen   = '0;
        @(negedge clk_i);
        cycle_step();
        l2_prefix_i = 16'($urandom);
        for (int c = 0; c < N; c++)
        begin
            trk_addr[c] = AW'($urandom);
            left[c]     = $urandom_range(12, 48);
            if (mode == M_ALIGNED)
            begin
                trk_addr[c][1:0] = 2'b00;
                left[c]          = 4 * $urandom_range(3, 10);
            end
            else if (mode == M_EVT)
                left[c] = $urandom_range(1, 9);
            cfg_addr_i[c] = trk_addr[c];
            cfg_size_i[c] = TRANS_SIZE'(left[c]);
            model_en[c]   = 1'b1;
            evt_cnt[c]    = 0;
            total_bytes  += left[c];
        end
        cfg_start_i = '1;
        wd_limit    = 40 * total_bytes;   // never more words than bytes
        wd_count    = 0;
        wd_armed    = 1'b1;
        @(negedge clk_i);
        cycle_step();
        cfg_start_i = '0;
        while (model_en != '0 || exp_q.size() != 0 || l2_req_o)
        begin
            @(negedge clk_i);
            cycle_step();
        end
        @(negedge clk_i);
        cycle_step();
        wd_armed = 1'b0;
        for (int c = 0; c < N; c++)
            compare($sformatf("evt_o[%0d] pulse count", c), 32'(evt_cnt[c]), 32'd1);
        if (mode == M_SPLIT && split_cnt == 0)
            note_error("no transfer crossed a word boundary");
        if (mode == M_PREFIX && dest_seen != 4'hF)
            note_error("not every destination code was used");
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
    endtask

    initial
    begin
        void'($urandom(32'h2bbd5091));
        rstn_i      = 1'b0;
        cfg_start_i = '0;
        cfg_clr_i   = '0;
        cfg_addr_i  = '0;
        cfg_size_i  = '0;
        ch_valid_i  = '0;
        ch_data_i   = '0;
        l2_prefix_i = '0;
        l2_gnt_i    = 1'b0;
        model_en    = '0;
        exp_evt     = '0;
        taken       = '0;
        for (int c = 0; c < N; c++)
        begin
            ch_size_i[c] = SIZE_BYTE;
            ch_dest_i[c] = DEST_L2;
            seen[c]      = '0;
        end
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        compare("l2_req_o", 32'(l2_req_o), 32'd0);
        compare("ch_ready_o", 32'(ch_ready_o), 32'd0);
        run_test("aligned writes", M_ALIGNED);
        run_test("split writes", M_SPLIT);
        run_test("address prefix", M_PREFIX);
        run_test("channel end of transfer", M_EVT);
        run_test("fairness and back-pressure", M_STRESS);
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // watchdog, armed per test
    initial
    begin
        while (!(wd_armed && wd_count > wd_limit))
        begin
            @(posedge clk_i);
            if (wd_armed)
                wd_count++;
        end
        $display("timeout: test %s did not finish within %0d cycles", test_name, wd_limit);
        $display("Errors found");
        $finish;
    end

endmodule

/* udma_rx_top.f */
src/udma_rx_pkg.sv
src/rx_arbiter.sv
src/rx_chan_addrgen.sv
src/rx_ingress.sv
src/rx_fifo.sv
src/rx_l2_writer.sv
src/udma_rx_top.sv
dv/udma_rx_checker.sv
dv/udma_rx_tb.sv

/* Makefile */
# Verilator build and run of the udma_rx_top testbench
# the run fails unless the log holds the pass line

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
		--top-module udma_rx_tb \
		-f udma_rx_top.f \
		--Mdir $(OBJ_DIR) -o Vudma_rx_tb

run: compile
	./$(OBJ_DIR)/Vudma_rx_tb | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
